// ==== common/alu_pkg.sv ====
package alu_pkg;

	// ==================================================
	// Major opcodes
	// ==================================================

	// Every register form shares OP_R3 and is told apart by func
	typedef enum logic [3:0] {
		OP_R3    = 4'h0,
		OP_ADDI  = 4'h1,
		OP_SUBFI = 4'h2,
		OP_ANDI  = 4'h3,
		OP_ORI   = 4'h4,
		OP_EORI  = 4'h5,
		OP_CMPI  = 4'h6,
		OP_CMPUI = 4'h7,
		OP_MULI  = 4'h8,
		OP_DIVI  = 4'h9,
		OP_MOV   = 4'ha,
		OP_NOP   = 4'hf
	} op_e;

	// ==================================================
	// Register-form functions
	// ==================================================

	typedef enum logic [4:0] {
		FN_ADD   = 5'd0,
		FN_SUB   = 5'd1,
		FN_AND   = 5'd2,
		FN_OR    = 5'd3,
		FN_EOR   = 5'd4,
		FN_NAND  = 5'd5,
		FN_NOR   = 5'd6,
		FN_CMP   = 5'd7,
		FN_CMPU  = 5'd8,
		FN_MUL   = 5'd9,
		FN_MULU  = 5'd10,
		FN_MULH  = 5'd11,
		FN_MULUH = 5'd12,
		FN_DIV   = 5'd13,
		FN_DIVU  = 5'd14,
		FN_MOD   = 5'd15,
		FN_MODU  = 5'd16,
		FN_MAX3  = 5'd17,
		FN_MIN3  = 5'd18,
		FN_MAXU3 = 5'd19,
		FN_MINU3 = 5'd20,
		FN_ASL   = 5'd21,
		FN_LSR   = 5'd22,
		FN_ASR   = 5'd23
	} func_e;

	// Folding of the third operand into a two-operand result
	// Codes 6 and 7 are unassigned and yield zero
	typedef enum logic [2:0] {
		CB_AND  = 3'd0,
		CB_ANDN = 3'd1,
		CB_OR   = 3'd2,
		CB_ORN  = 3'd3,
		CB_XOR  = 3'd4,
		CB_XNOR = 3'd5
	} combine_e;

	// Bit positions of the compare flags in a compare result
	localparam int unsigned CMP_EQ = 0;
	localparam int unsigned CMP_LT = 1;
	localparam int unsigned CMP_LE = 2;
	localparam int unsigned CMP_GT = 3;
	localparam int unsigned CMP_GE = 4;

endpackage

// ==== common/exec_pkg.sv ====
package exec_pkg;

	// ==================================================
	// Unit timing
	// ==================================================

	// Register stages between operand capture and the product output
	localparam int unsigned MUL_STAGES = 3;

	// Sequencer waits in ONE, MUL or DIV until the chosen path is done
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ONE  = 2'd1,
		ST_MUL  = 2'd2,
		ST_DIV  = 2'd3
	} seq_state_e;

	// DONE lasts exactly one cycle and is the divider's done pulse
	typedef enum logic [1:0] {
		DV_IDLE = 2'd0,
		DV_RUN  = 2'd1,
		DV_DONE = 2'd2
	} div_state_e;

endpackage

// ==== alu/alu_core.sv ====
`timescale 1ns/1ps

module alu_core
	import alu_pkg::*;
	import exec_pkg::*;
#(
	parameter int WID = 32
)
(
	input  logic           clk,
	input  logic           rst_n,
	input  op_e            op_q,
	input  func_e          func_q,
	input  combine_e       combine_q,
	input  logic [WID-1:0] a_q,
	input  logic [WID-1:0] b_q,
	input  logic [WID-1:0] c_q,
	input  logic [WID-1:0] imm_q,
	input  logic           mul_start,
	input  logic [WID-1:0] quotient,
	input  logic [WID-1:0] remainder,
	output logic [WID-1:0] result,
	output logic           mul_done
);

	localparam int SHW = $clog2(WID);

	logic [WID-1:0]        mul_b;
	logic [2*WID-1:0]      prod_s [MUL_STAGES];
	logic [2*WID-1:0]      prod_u [MUL_STAGES];
	logic [2*WID-1:0]      prod_s_out;
	logic [2*WID-1:0]      prod_u_out;
	logic [MUL_STAGES-1:0] mul_tok;
	logic [SHW-1:0]        sh_amt;

	// ==================================================
	// Result helpers
	// ==================================================

	// Fold c into a two-operand result, inverting afterwards for NAND and NOR
	function automatic logic [WID-1:0] fold(input logic [WID-1:0] base,
		input logic [WID-1:0] cv, input combine_e mode, input logic inv);
		logic [WID-1:0] v;
		case (mode)
			CB_AND:  v = base & cv;
			CB_ANDN: v = base & ~cv;
			CB_OR:   v = base | cv;
			CB_ORN:  v = base | ~cv;
			CB_XOR:  v = base ^ cv;
			CB_XNOR: v = base ^ ~cv;
			default: return '0;
		endcase
		return inv ? ~v : v;
	endfunction

	function automatic logic [WID-1:0] cmp_flags(input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic sgn);
		logic           eq;
		logic           lt;
		logic [WID-1:0] f;
		eq = (x == y);
		lt = sgn ? ($signed(x) < $signed(y)) : (x < y);
		f = '0;
		f[CMP_EQ] = eq;
		f[CMP_LT] = lt;
		f[CMP_LE] = lt | eq;
		f[CMP_GT] = ~(lt | eq);
		f[CMP_GE] = ~lt;
		return f;
	endfunction

	// True when p strictly wins over q in the requested direction
	function automatic logic ahead(input logic [WID-1:0] p, input logic [WID-1:0] q,
		input logic sgn, input logic is_max);
		logic lt;
		lt = sgn ? ($signed(p) < $signed(q)) : (p < q);
		return is_max ? (!lt && (p != q)) : lt;
	endfunction

	// Ties fall through to the later operand, which holds the same value
	function automatic logic [WID-1:0] pick3(input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic [WID-1:0] z, input logic sgn,
		input logic is_max);
		if (ahead(x, y, sgn, is_max) && ahead(x, z, sgn, is_max))
			return x;
		if (ahead(y, z, sgn, is_max))
			return y;
		return z;
	endfunction

	// ==================================================
	// Product pipeline
	// ==================================================

	assign mul_b = (op_q == OP_MULI) ? imm_q : b_q;

	// Operands are widened by hand so the low 2*WID bits hold the full product
	always_ff @(posedge clk)
	begin
		prod_s[0] <= {{WID{a_q[WID-1]}}, a_q} * {{WID{mul_b[WID-1]}}, mul_b};
		prod_u[0] <= {{WID{1'b0}}, a_q} * {{WID{1'b0}}, mul_b};
		for (int i = 1; i < MUL_STAGES; i++)
		begin
			prod_s[i] <= prod_s[i-1];
			prod_u[i] <= prod_u[i-1];
		end
	end

	// A single token walks beside the product and marks the last stage
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mul_tok <= '0;
		else
			mul_tok <= {mul_tok[MUL_STAGES-2:0], mul_start};
	end

	assign mul_done   = mul_tok[MUL_STAGES-1];
	assign prod_s_out = prod_s[MUL_STAGES-1];
	assign prod_u_out = prod_u[MUL_STAGES-1];

	// ==================================================
	// Result select
	// ==================================================

	assign sh_amt = c_q[SHW-1:0];

	always_comb
	begin
		result = '0;
		case (op_q)
			OP_R3:
				case (func_q)
					FN_ADD:   result = fold(a_q + b_q, c_q, combine_q, 1'b0);
					FN_SUB:   result = a_q - b_q;
					FN_AND:   result = fold(a_q & b_q, c_q, combine_q, 1'b0);
					FN_OR:    result = fold(a_q | b_q, c_q, combine_q, 1'b0);
					FN_EOR:   result = fold(a_q ^ b_q, c_q, combine_q, 1'b0);
					FN_NAND:  result = fold(a_q & b_q, c_q, combine_q, 1'b1);
					FN_NOR:   result = fold(a_q | b_q, c_q, combine_q, 1'b1);
					FN_CMP:   result = cmp_flags(a_q, b_q, 1'b1);
					FN_CMPU:  result = cmp_flags(a_q, b_q, 1'b0);
					FN_MUL:   result = prod_s_out[WID-1:0];
					FN_MULU:  result = prod_u_out[WID-1:0];
					FN_MULH:  result = prod_s_out[2*WID-1:WID];
					FN_MULUH: result = prod_u_out[2*WID-1:WID];
					FN_DIV:   result = quotient;
					FN_DIVU:  result = quotient;
					FN_MOD:   result = remainder;
					FN_MODU:  result = remainder;
					FN_MAX3:  result = pick3(a_q, b_q, c_q, 1'b1, 1'b1);
					FN_MIN3:  result = pick3(a_q, b_q, c_q, 1'b1, 1'b0);
					FN_MAXU3: result = pick3(a_q, b_q, c_q, 1'b0, 1'b1);
					FN_MINU3: result = pick3(a_q, b_q, c_q, 1'b0, 1'b0);
					FN_ASL:   result = a_q << sh_amt;
					FN_LSR:   result = a_q >> sh_amt;
					FN_ASR:   result = $unsigned($signed(a_q) >>> sh_amt);
					default:  result = '0;
				endcase
			OP_ADDI:  result = a_q + imm_q;
			OP_SUBFI: result = imm_q - a_q;
			OP_ANDI:  result = a_q & imm_q;
			OP_ORI:   result = a_q | imm_q;
			OP_EORI:  result = a_q ^ imm_q;
			OP_CMPI:  result = cmp_flags(a_q, imm_q, 1'b1);
			OP_CMPUI: result = cmp_flags(a_q, imm_q, 1'b0);
			OP_MULI:  result = prod_s_out[WID-1:0];
			OP_DIVI:  result = quotient;
			OP_MOV:   result = a_q;
			default:  result = '0;
		endcase
	end

endmodule

// ==== alu/alu_divider.sv ====
`timescale 1ns/1ps

module alu_divider
	import exec_pkg::*;
#(
	parameter int WID = 32
)
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           div_start,
	input  logic           div_signed,
	input  logic [WID-1:0] dividend,
	input  logic [WID-1:0] divisor,
	output logic [WID-1:0] quotient,
	output logic [WID-1:0] remainder,
	output logic           dbz,
	output logic           div_done
);

	localparam int CW = $clog2(WID) + 1;

	div_state_e     state;
	logic [CW-1:0]  cnt;
	logic           neg_q;
	logic           neg_r;
	logic           dbz_q;
	logic           b_zero;
	logic [WID-1:0] a_mag;
	logic [WID-1:0] b_mag;
	// Dividend bits leave at the top while quotient bits enter at the bottom
	logic [WID-1:0] q_r;
	logic [WID-1:0] dmag;
	logic [WID-1:0] acc;
	logic [WID:0]   acc_sh;
	logic [WID:0]   trial;

	assign b_zero = (divisor == '0);
	assign a_mag  = (div_signed && dividend[WID-1]) ? -dividend : dividend;
	assign b_mag  = (div_signed && divisor[WID-1]) ? -divisor : divisor;

	assign acc_sh = {acc, q_r[WID-1]};
	assign trial  = acc_sh - {1'b0, dmag};

	// ==================================================
	// Control
	// ==================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= DV_IDLE;
			cnt   <= '0;
			neg_q <= 1'b0;
			neg_r <= 1'b0;
			dbz_q <= 1'b0;
		end
		else if (div_start)
		begin
			// A zero divisor skips the iterations and keeps the raw dividend
			neg_q <= div_signed && (dividend[WID-1] ^ divisor[WID-1]) && !b_zero;
			neg_r <= div_signed && dividend[WID-1] && !b_zero;
			dbz_q <= b_zero;
			cnt   <= CW'(WID);
			state <= b_zero ? DV_DONE : DV_RUN;
		end
		else
		begin
			case (state)
				DV_RUN:
				begin
					cnt <= cnt - 1'b1;
					if (cnt == CW'(1))
						state <= DV_DONE;
				end
				default: state <= DV_IDLE;
			endcase
		end
	end

	// ==================================================
	// Shift-subtract datapath
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (div_start)
		begin
			q_r  <= b_zero ? '1 : a_mag;
			acc  <= b_zero ? dividend : '0;
			dmag <= b_mag;
		end
		else if (state == DV_RUN)
		begin
			// Keep the trial difference only when it did not borrow
			if (!trial[WID])
			begin
				acc <= trial[WID-1:0];
				q_r <= {q_r[WID-2:0], 1'b1};
			end
			else
			begin
				acc <= acc_sh[WID-1:0];
				q_r <= {q_r[WID-2:0], 1'b0};
			end
		end
	end

	assign div_done  = (state == DV_DONE);
	assign dbz       = div_done && dbz_q;
	assign quotient  = neg_q ? -q_r : q_r;
	assign remainder = neg_r ? -acc : acc;

endmodule

// ==== logic/exec_sequencer.sv ====
`timescale 1ns/1ps

module exec_sequencer
	import alu_pkg::*;
	import exec_pkg::*;
#(
	parameter int WID = 32
)
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           issue,
	input  op_e            opcode,
	input  func_e          func,
	input  combine_e       combine,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	input  logic [WID-1:0] c,
	input  logic [WID-1:0] imm,
	input  logic           mul_done,
	input  logic           div_done,
	output op_e            op_q,
	output func_e          func_q,
	output combine_e       combine_q,
	output logic [WID-1:0] a_q,
	output logic [WID-1:0] b_q,
	output logic [WID-1:0] c_q,
	output logic [WID-1:0] imm_q,
	output logic           mul_start,
	output logic           div_start,
	output logic           div_signed,
	output logic           busy,
	output logic           result_valid
);

	seq_state_e state;
	logic       rv_q;
	logic       accept;
	logic       is_mul;
	logic       is_div;

	// Strobes that arrive while an operation is in flight are dropped
	assign accept = issue && !busy;

	assign is_mul = (opcode == OP_MULI) ||
		((opcode == OP_R3) && (func inside {FN_MUL, FN_MULU, FN_MULH, FN_MULUH}));
	assign is_div = (opcode == OP_DIVI) ||
		((opcode == OP_R3) && (func inside {FN_DIV, FN_DIVU, FN_MOD, FN_MODU}));

	assign div_signed = (op_q == OP_DIVI) ||
		((op_q == OP_R3) && (func_q inside {FN_DIV, FN_MOD}));

	// Busy covers the result cycle as well, so a new issue waits one more edge
	assign busy         = (state != ST_IDLE) || rv_q;
	assign result_valid = rv_q || ((state == ST_DIV) && div_done);

	// ==================================================
	// Operation capture
	// ==================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			op_q      <= OP_NOP;
			func_q    <= FN_ADD;
			combine_q <= CB_AND;
		end
		else if (accept)
		begin
			op_q      <= opcode;
			func_q    <= func;
			combine_q <= combine;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			a_q   <= a;
			b_q   <= b;
			c_q   <= c;
			imm_q <= imm;
		end
	end

	// ==================================================
	// Path FSM
	// ==================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= ST_IDLE;
			rv_q      <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
		end
		else
		begin
			rv_q      <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			case (state)
				ST_IDLE:
					if (accept)
					begin
						if (is_div)
						begin
							state     <= ST_DIV;
							div_start <= 1'b1;
						end
						else if (is_mul)
						begin
							state     <= ST_MUL;
							mul_start <= 1'b1;
						end
						else
							state <= ST_ONE;
					end
				ST_ONE:
				begin
					rv_q  <= 1'b1;
					state <= ST_IDLE;
				end
				ST_MUL:
					if (mul_done)
					begin
						rv_q  <= 1'b1;
						state <= ST_IDLE;
					end
				// The divide result is flagged straight from div_done
				ST_DIV:
					if (div_done)
						state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
	import alu_pkg::*;
#(
	parameter int WID = 32
)
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           issue,
	input  op_e            opcode,
	input  func_e          func,
	input  combine_e       combine,
	input  logic [WID-1:0] a,
	input  logic [WID-1:0] b,
	input  logic [WID-1:0] c,
	input  logic [WID-1:0] imm,
	output logic [WID-1:0] result,
	output logic           result_valid,
	output logic           div_by_zero,
	output logic           busy
);

	op_e            op_q;
	func_e          func_q;
	combine_e       combine_q;
	logic [WID-1:0] a_q;
	logic [WID-1:0] b_q;
	logic [WID-1:0] c_q;
	logic [WID-1:0] imm_q;
	logic [WID-1:0] divisor;
	logic [WID-1:0] quotient;
	logic [WID-1:0] remainder;
	logic           mul_start;
	logic           mul_done;
	logic           div_start;
	logic           div_signed;
	logic           div_done;

	// The immediate divide takes its divisor from imm, register forms from b
	assign divisor = (op_q == OP_DIVI) ? imm_q : b_q;

	exec_sequencer #(.WID(WID)) seq0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue),
		.opcode       (opcode),
		.func         (func),
		.combine      (combine),
		.a            (a),
		.b            (b),
		.c            (c),
		.imm          (imm),
		.mul_done     (mul_done),
		.div_done     (div_done),
		.op_q         (op_q),
		.func_q       (func_q),
		.combine_q    (combine_q),
		.a_q          (a_q),
		.b_q          (b_q),
		.c_q          (c_q),
		.imm_q        (imm_q),
		.mul_start    (mul_start),
		.div_start    (div_start),
		.div_signed   (div_signed),
		.busy         (busy),
		.result_valid (result_valid)
	);

	alu_core #(.WID(WID)) core0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_q      (op_q),
		.func_q    (func_q),
		.combine_q (combine_q),
		.a_q       (a_q),
		.b_q       (b_q),
		.c_q       (c_q),
		.imm_q     (imm_q),
		.mul_start (mul_start),
		.quotient  (quotient),
		.remainder (remainder),
		.result    (result),
		.mul_done  (mul_done)
	);

	alu_divider #(.WID(WID)) div0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.div_start  (div_start),
		.div_signed (div_signed),
		.dividend   (a_q),
		.divisor    (divisor),
		.quotient   (quotient),
		.remainder  (remainder),
		.dbz        (div_by_zero),
		.div_done   (div_done)
	);

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
#(
	parameter int PERIOD = 8
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

endmodule

// ==== testbench/exec_properties.sv ====
`timescale 1ns/1ps

module exec_properties
(
	input logic clk,
	input logic rst_n,
	input logic result_valid,
	input logic busy,
	input logic mul_start,
	input logic div_start
);

	// The result is presented for exactly one cycle
	a_rv_single: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |=> !result_valid)
		else $error("result_valid high on two consecutive cycles");

	// Busy may only drop at the edge that closes a result cycle
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(result_valid))
		else $error("busy fell without a preceding result_valid");

	a_one_path: assert property (@(posedge clk) disable iff (!rst_n)
		!(mul_start && div_start))
		else $error("mul_start and div_start high in the same cycle");

endmodule

bind exec_sequencer exec_properties props0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.result_valid (result_valid),
	.busy         (busy),
	.mul_start    (mul_start),
	.div_start    (div_start)
);

// ==== testbench/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb
	import alu_pkg::*;
();

	localparam int WID         = 32;
	localparam int N_LOGIC     = 60;
	localparam int N_IMM       = 60;
	localparam int N_MINMAX    = 40;
	localparam int N_MUL       = 40;
	localparam int N_DIV       = 48;
	// Directed divides and the dropped-strobe sequence
	localparam int N_EXTRA     = 8;
	localparam int TOTAL_OPS   = N_LOGIC + N_IMM + N_MINMAX + N_MUL + N_DIV + N_EXTRA;
	localparam int CYCLE_LIMIT = TOTAL_OPS * (WID + 8);

	logic           clk;
	logic           rst_n;
	logic           issue;
	op_e            opcode;
	func_e          func;
	combine_e       combine;
	logic [WID-1:0] a;
	logic [WID-1:0] b;
	logic [WID-1:0] c;
	logic [WID-1:0] imm;
	logic [WID-1:0] result;
	logic           result_valid;
	logic           div_by_zero;
	logic           busy;

	logic [31:0]    lfsr;
	int             errors;
	int             checks;
	int             ops;
	int             tests;
	int             cycles;
	func_e          logic_fns [7];
	func_e          r3_fns [5];
	func_e          mm_fns [4];
	func_e          mul_fns [4];
	func_e          div_fns [4];
	op_e            imm_ops [9];

	tb_clock #(.PERIOD(8)) clk0 (.clk(clk));

	exec_unit #(.WID(WID)) dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue),
		.opcode       (opcode),
		.func         (func),
		.combine      (combine),
		.a            (a),
		.b            (b),
		.c            (c),
		.imm          (imm),
		.result       (result),
		.result_valid (result_valid),
		.div_by_zero  (div_by_zero),
		.busy         (busy)
	);

	// ==================================================
	// Random numbers and reference model
	// ==================================================

	// Galois form of x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [WID-1:0] fold_expect(input logic [WID-1:0] r,
		input logic [WID-1:0] cv, input combine_e cb, input logic inv);
		logic [WID-1:0] v;
		case (cb)
			CB_AND:  v = r & cv;
			CB_ANDN: v = r & ~cv;
			CB_OR:   v = r | cv;
			CB_ORN:  v = r | ~cv;
			CB_XOR:  v = r ^ cv;
			CB_XNOR: v = ~(r ^ cv);
			default: return '0;
		endcase
		return inv ? ~v : v;
	endfunction

	// Bits from the top: ge, gt, le, lt, eq
	function automatic logic [WID-1:0] flags_expect(input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic sgn);
		logic lt;
		logic eq;
		eq = (x == y);
		lt = sgn ? ($signed(x) < $signed(y)) : (x < y);
		return {{(WID-5){1'b0}}, !lt, !lt && !eq, lt || eq, lt, eq};
	endfunction

	function automatic longint rank(input logic [WID-1:0] v, input logic sgn);
		return sgn ? longint'($signed(v)) : longint'({1'b0, v});
	endfunction

	function automatic logic [WID-1:0] extreme3(input logic [WID-1:0] x,
		input logic [WID-1:0] y, input logic [WID-1:0] z, input logic sgn,
		input logic want_max);
		logic [WID-1:0] best;
		best = x;
		if (want_max ? rank(y, sgn) > rank(best, sgn) : rank(y, sgn) < rank(best, sgn))
			best = y;
		if (want_max ? rank(z, sgn) > rank(best, sgn) : rank(z, sgn) < rank(best, sgn))
			best = z;
		return best;
	endfunction

	function automatic logic is_multiply(input op_e op, input func_e fn);
		return (op == OP_MULI) ||
			((op == OP_R3) && (fn inside {FN_MUL, FN_MULU, FN_MULH, FN_MULUH}));
	endfunction

	function automatic logic is_divide(input op_e op, input func_e fn);
		return (op == OP_DIVI) ||
			((op == OP_R3) && (fn inside {FN_DIV, FN_DIVU, FN_MOD, FN_MODU}));
	endfunction

	function automatic logic model_dbz(input op_e op, input func_e fn,
		input logic [WID-1:0] y, input logic [WID-1:0] k);
		return is_divide(op, fn) && (((op == OP_DIVI) ? k : y) == '0);
	endfunction

	function automatic logic [WID-1:0] model_result(input op_e op, input func_e fn,
		input combine_e cb, input logic [WID-1:0] x, input logic [WID-1:0] y,
		input logic [WID-1:0] z, input logic [WID-1:0] k);
		logic [WID-1:0]   m;
		logic [WID-1:0]   dv;
		logic [WID-1:0]   quo;
		logic [WID-1:0]   rem;
		logic [2*WID-1:0] sp;
		logic [2*WID-1:0] up;
		longint           sq;
		longint           sr;
		int               amt;
		m   = (op == OP_MULI) ? k : y;
		dv  = (op == OP_DIVI) ? k : y;
		sp  = longint'($signed(x)) * longint'($signed(m));
		up  = {{WID{1'b0}}, x} * {{WID{1'b0}}, m};
		amt = int'(z[$clog2(WID)-1:0]);
		// Zero divisor gives all ones and hands the dividend back as remainder
		if (dv == '0)
		begin
			quo = '1;
			rem = x;
		end
		else if ((op == OP_DIVI) || (fn inside {FN_DIV, FN_MOD}))
		begin
			sq  = longint'($signed(x)) / longint'($signed(dv));
			sr  = longint'($signed(x)) % longint'($signed(dv));
			quo = sq[WID-1:0];
			rem = sr[WID-1:0];
		end
		else
		begin
			quo = x / dv;
			rem = x % dv;
		end
		case (op)
			OP_ADDI:  return x + k;
			OP_SUBFI: return k - x;
			OP_ANDI:  return x & k;
			OP_ORI:   return x | k;
			OP_EORI:  return x ^ k;
			OP_CMPI:  return flags_expect(x, k, 1'b1);
			OP_CMPUI: return flags_expect(x, k, 1'b0);
			OP_MULI:  return sp[WID-1:0];
			OP_DIVI:  return quo;
			OP_MOV:   return x;
			OP_R3:    ;
			default:  return '0;
		endcase
		case (fn)
			FN_ADD:   return fold_expect(x + y, z, cb, 1'b0);
			FN_SUB:   return x - y;
			FN_AND:   return fold_expect(x & y, z, cb, 1'b0);
			FN_OR:    return fold_expect(x | y, z, cb, 1'b0);
			FN_EOR:   return fold_expect(x ^ y, z, cb, 1'b0);
			FN_NAND:  return fold_expect(x & y, z, cb, 1'b1);
			FN_NOR:   return fold_expect(x | y, z, cb, 1'b1);
			FN_CMP:   return flags_expect(x, y, 1'b1);
			FN_CMPU:  return flags_expect(x, y, 1'b0);
			FN_MUL:   return sp[WID-1:0];
			FN_MULU:  return up[WID-1:0];
			FN_MULH:  return sp[2*WID-1:WID];
			FN_MULUH: return up[2*WID-1:WID];
			FN_DIV:   return quo;
			FN_DIVU:  return quo;
			FN_MOD:   return rem;
			FN_MODU:  return rem;
			FN_MAX3:  return extreme3(x, y, z, 1'b1, 1'b1);
			FN_MIN3:  return extreme3(x, y, z, 1'b1, 1'b0);
			FN_MAXU3: return extreme3(x, y, z, 1'b0, 1'b1);
			FN_MINU3: return extreme3(x, y, z, 1'b0, 1'b0);
			FN_ASL:   return x << amt;
			FN_LSR:   return x >> amt;
			FN_ASR:   return $signed(x) >>> amt;
			default:  return '0;
		endcase
	endfunction

	// ==================================================
	// Driving and checking
	// ==================================================

	task automatic compare(input string name, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic launch(input op_e op, input func_e fn, input combine_e cb,
		input logic [WID-1:0] x, input logic [WID-1:0] y, input logic [WID-1:0] z,
		input logic [WID-1:0] k);
		@(negedge clk);
		opcode  = op;
		func    = fn;
		combine = cb;
		a       = x;
		b       = y;
		c       = z;
		imm     = k;
		issue   = 1'b1;
	endtask

	// Counts the edges after the sampling edge until the result shows up
	task automatic collect(output int edges);
		@(negedge clk);
		issue = 1'b0;
		edges = 0;
		while (!result_valid)
		begin
			if (div_by_zero)
			begin
				errors++;
				$display("ERROR t=%0t: div_by_zero is high outside a result cycle", $time);
			end
			@(negedge clk);
			edges++;
		end
	endtask

	task automatic run_op(input op_e op, input func_e fn, input combine_e cb,
		input logic [WID-1:0] x, input logic [WID-1:0] y, input logic [WID-1:0] z,
		input logic [WID-1:0] k);
		logic [WID-1:0] want;
		logic           want_dbz;
		int             edges;
		want     = model_result(op, fn, cb, x, y, z, k);
		want_dbz = model_dbz(op, fn, y, k);
		launch(op, fn, cb, x, y, z, k);
		collect(edges);
		ops++;
		compare("result", result, want);
		compare("div_by_zero", div_by_zero, want_dbz);
		if (is_multiply(op, fn))
			compare("mul_latency", edges, 4);
		else if (!is_divide(op, fn))
			compare("latency", edges, 1);
	endtask

	task automatic report_test(input string name, input int err0, input int ops0);
		tests++;
		$display("test %s: %0d operations, %0d errors", name, ops - ops0, errors - err0);
	endtask

	// ==================================================
	// Watchdog
	// ==================================================

	initial
	begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial
	begin : main
		logic [WID-1:0] x;
		logic [WID-1:0] y;
		logic [WID-1:0] z;
		logic [WID-1:0] k;
		logic [WID-1:0] want;
		logic [31:0]    bits;
		int             sel;
		int             err0;
		int             ops0;
		int             edges;
		op_e            op;
		func_e          fn;
		combine_e       cb;

		lfsr      = 32'hcf766784;
		errors    = 0;
		checks    = 0;
		ops       = 0;
		tests     = 0;
		logic_fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR};
		r3_fns    = '{FN_CMP, FN_CMPU, FN_ASL, FN_LSR, FN_ASR};
		mm_fns    = '{FN_MAX3, FN_MIN3, FN_MAXU3, FN_MINU3};
		mul_fns   = '{FN_MUL, FN_MULU, FN_MULH, FN_MULUH};
		div_fns   = '{FN_DIV, FN_DIVU, FN_MOD, FN_MODU};
		imm_ops   = '{OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_EORI, OP_CMPI, OP_CMPUI,
			OP_MOV, OP_NOP};

		rst_n   = 1'b0;
		issue   = 1'b0;
		opcode  = OP_NOP;
		func    = FN_ADD;
		combine = CB_AND;
		a       = '0;
		b       = '0;
		c       = '0;
		imm     = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Logic and add with every combine code, the two spare ones included
		err0 = errors;
		ops0 = ops;
		for (int i = 0; i < N_LOGIC; i++)
		begin
			bits = take_bits(3);
			sel  = int'(bits % 7);
			bits = take_bits(3);
			cb   = combine_e'(bits[2:0]);
			x    = take_bits(WID);
			y    = take_bits(WID);
			z    = take_bits(WID);
			run_op(OP_R3, logic_fns[sel], cb, x, y, z, '0);
		end
		report_test("logic_add", err0, ops0);

		err0 = errors;
		ops0 = ops;
		for (int i = 0; i < N_IMM; i++)
		begin
			x    = take_bits(WID);
			y    = take_bits(WID);
			z    = take_bits(WID);
			k    = take_bits(WID);
			bits = take_bits(2);
			if (bits[1:0] == 2'd0)
			begin
				y = x;
				k = x;
			end
			bits = take_bits(4);
			sel  = int'(bits % 14);
			op   = (sel < 9) ? imm_ops[sel] : OP_R3;
			fn   = (sel < 9) ? FN_ADD : r3_fns[sel-9];
			run_op(op, fn, CB_AND, x, y, z, k);
		end
		report_test("imm_cmp_shift", err0, ops0);

		err0 = errors;
		ops0 = ops;
		for (int i = 0; i < N_MINMAX; i++)
		begin
			x    = take_bits(WID);
			y    = take_bits(WID);
			z    = take_bits(WID);
			bits = take_bits(2);
			case (bits[1:0])
				2'd0: y = x;
				2'd1: z = y;
				2'd2:
				begin
					y = x;
					z = x;
				end
				default: ;
			endcase
			bits = take_bits(2);
			run_op(OP_R3, mm_fns[bits[1:0]], CB_AND, x, y, z, '0);
		end
		report_test("minmax3", err0, ops0);

		err0 = errors;
		ops0 = ops;
		for (int i = 0; i < N_MUL; i++)
		begin
			x    = take_bits(WID);
			y    = take_bits(WID);
			k    = take_bits(WID);
			bits = take_bits(3);
			sel  = int'(bits % 5);
			if (sel < 4)
				run_op(OP_R3, mul_fns[sel], CB_AND, x, y, '0, k);
			else
				run_op(OP_MULI, FN_ADD, CB_AND, x, y, '0, k);
		end
		report_test("multiply", err0, ops0);

		err0 = errors;
		ops0 = ops;
		for (int i = 0; i < N_DIV; i++)
		begin
			x    = take_bits(WID);
			y    = take_bits(WID);
			k    = take_bits(WID);
			bits = take_bits(2);
			if (bits[1:0] == 2'd0)
			begin
				y = '0;
				k = '0;
			end
			else if (bits[1:0] == 2'd1)
			begin
				y = {{(WID-8){y[7]}}, y[7:0]};
				k = {{(WID-8){k[7]}}, k[7:0]};
			end
			bits = take_bits(3);
			sel  = int'(bits % 5);
			if (sel < 4)
				run_op(OP_R3, div_fns[sel], CB_AND, x, y, '0, k);
			else
				run_op(OP_DIVI, FN_ADD, CB_AND, x, y, '0, k);
		end
		run_op(OP_R3, FN_DIV, CB_AND, -32'd7, 32'd2, '0, '0);
		run_op(OP_R3, FN_MOD, CB_AND, -32'd7, 32'd2, '0, '0);
		run_op(OP_R3, FN_DIV, CB_AND, 32'd7, -32'd2, '0, '0);
		run_op(OP_R3, FN_MOD, CB_AND, -32'd9, '0, '0, '0);
		run_op(OP_DIVI, FN_ADD, CB_AND, 32'd100, '0, '0, 32'd3);
		report_test("divide", err0, ops0);

		// A MOV strobed mid-divide and another in the result cycle must both vanish
		err0 = errors;
		ops0 = ops;
		x    = take_bits(WID);
		want = model_result(OP_R3, FN_DIVU, CB_AND, x, 32'd7, '0, '0);
		launch(OP_R3, FN_DIVU, CB_AND, x, 32'd7, '0, '0);
		@(negedge clk);
		issue = 1'b0;
		repeat (3) @(negedge clk);
		launch(OP_MOV, FN_ADD, CB_AND, ~x, '0, '0, '0);
		collect(edges);
		ops++;
		compare("result", result, want);
		issue = 1'b1;
		@(negedge clk);
		issue = 1'b0;
		for (int i = 0; i < WID + 4; i++)
		begin
			if (result_valid)
			begin
				errors++;
				$display("ERROR t=%0t: result_valid pulsed for a strobe given while busy",
					$time);
			end
			@(negedge clk);
		end
		compare("busy", busy, 1'b0);
		run_op(OP_MOV, FN_ADD, CB_AND, x, '0, '0, '0);
		report_test("busy_drop", err0, ops0);

		$display("summary: %0d tests, %0d operations, %0d checks, %0d errors",
			tests, ops, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
common/alu_pkg.sv
common/exec_pkg.sv
alu/alu_core.sv
alu/alu_divider.sv
logic/exec_sequencer.sv
logic/exec_unit.sv
testbench/tb_clock.sv
testbench/exec_properties.sv
testbench/exec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exec_tb -Mdir obj_dir -f flist.f \
	&& ./obj_dir/Vexec_tb | tee /dev/stderr | grep -F "STATUS: PASS" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation did not pass"; exit 1; }
